// ==== Bender.yml ====
package:
  name: qcbr

sources:
  - common/qcbr_pkg.sv
  - hw/core_ctrl/qcbr_core_ctrl.sv
  - hw/mac_array/qcbr_mac_array.sv
  - hw/qcbr_bias_add.sv
  - hw/qcbr_relu_scale.sv
  - hw/qcbr_out_fifo.sv
  - hw/qcbr_top.sv
  - target: test
    files:
      - tests/qcbr_tb.sv

// ==== build.f ====
common/qcbr_pkg.sv
hw/core_ctrl/qcbr_core_ctrl.sv
hw/mac_array/qcbr_mac_array.sv
hw/qcbr_bias_add.sv
hw/qcbr_relu_scale.sv
hw/qcbr_out_fifo.sv
hw/qcbr_top.sv
tests/qcbr_tb.sv

// ==== common/qcbr_pkg.sv ====
package qcbr_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W  = 8;   // Pixels, weights and int8 results
  localparam int ACC_W   = 32;  // Accumulators and bias words
  localparam int SCALE_W = 16;  // Unsigned requant multiplier
  localparam int SHIFT_W = 5;   // Arithmetic right shift amount

  ////////////////////////////////////////////////////////////
  // Array and sequencing
  ////////////////////////////////////////////////////////////

  // One row per output channel of a tile
  localparam int ROWS      = 8;
  localparam int ROW_IDX_W = 3;
  localparam int CNT_W     = 16;  // Pixel loop counter

  ////////////////////////////////////////////////////////////
  // Result FIFO
  ////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;  // Free count is one bit wider

endpackage

// ==== hw/core_ctrl/qcbr_core_ctrl.sv ====
`timescale 1ns/1ps

module qcbr_core_ctrl import qcbr_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tile_start,
  input  logic                 relu_init,
  input  logic [CNT_W-1:0]     pixel_count_init,
  input  logic [FIFO_AW:0]     fifo_free,
  output logic                 relu_mode,
  output logic                 mac_en,
  output logic                 mac_clear,
  output logic [ROW_IDX_W-1:0] row_idx,
  output logic                 bias_en,
  output logic                 act_en,
  output logic                 fifo_wr,
  output logic                 tile_busy,
  output logic                 tile_done
);

  logic [CNT_W-1:0]     pixel_count;  // Last pixel index N
  logic                 accept;
  logic                 pix_active;
  logic [CNT_W-1:0]     pix_cnt;
  logic                 pix_begin;
  logic                 pix_last;
  logic                 drain_active;
  logic [ROW_IDX_W-1:0] drain_cnt;
  logic                 drain_last;

  // Mode and pixel count latched while reset is held
  always_ff @(posedge clk) begin
    if (reset) begin
      relu_mode   <= relu_init;
      pixel_count <= pixel_count_init;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pixel loop
  ////////////////////////////////////////////////////////////

  // Need room for a whole tile of results before starting
  assign accept = tile_start && !tile_busy && (fifo_free >= (FIFO_AW + 1)'(ROWS));

  assign pix_begin = accept || pix_active;  // Accept cycle is pixel 0
  assign pix_last  = pix_begin && (pix_cnt == pixel_count);
  assign mac_en    = pix_begin;

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_active <= 1'b0;
    end else if (pix_last) begin
      pix_active <= 1'b0;
    end else if (accept) begin
      pix_active <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
    end else if (pix_begin) begin
      if (pix_last) begin
        pix_cnt <= '0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drain loop, one row per cycle
  ////////////////////////////////////////////////////////////

  assign drain_last = drain_active && (drain_cnt == ROW_IDX_W'(ROWS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_active <= 1'b0;
    end else if (pix_last) begin
      drain_active <= 1'b1;
    end else if (drain_last) begin
      drain_active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_cnt <= '0;
    end else if (drain_active) begin
      if (drain_last) begin
        drain_cnt <= '0;
      end else begin
        drain_cnt <= drain_cnt + 1'b1;
      end
    end
  end

  assign row_idx = drain_cnt;
  assign bias_en = drain_active;  // Bias stage samples on this edge

  // Enable and end-of-tile bits step down with the data
  always_ff @(posedge clk) begin
    if (reset) begin
      act_en    <= 1'b0;
      fifo_wr   <= 1'b0;
      mac_clear <= 1'b0;
      tile_done <= 1'b0;
    end else begin
      act_en    <= bias_en;
      fifo_wr   <= act_en;
      mac_clear <= drain_last;  // Also the end bit of the act stage
      tile_done <= mac_clear;   // Lines up with the last FIFO write
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tile_busy <= 1'b0;
    end else if (accept) begin
      tile_busy <= 1'b1;
    end else if (tile_done) begin
      tile_busy <= 1'b0;
    end
  end

  // A new tile only starts once the previous one has left the whole pipeline
  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    accept |-> !(pix_active || drain_active || act_en || fifo_wr || mac_clear));

  a_wr_room: assert property (@(posedge clk) disable iff (reset)
    fifo_wr |-> (fifo_free != '0));

endmodule

// ==== hw/mac_array/qcbr_mac_array.sv ====
`timescale 1ns/1ps

module qcbr_mac_array import qcbr_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          mac_en,
  input  logic                          mac_clear,
  input  logic signed [DATA_W-1:0]      pixel,
  input  logic [ROWS-1:0][DATA_W-1:0]   weights,
  input  logic [ROW_IDX_W-1:0]          row_idx,
  output logic signed [ACC_W-1:0]       row_acc
);

  logic signed [ACC_W-1:0]      acc [ROWS];
  logic signed [2*DATA_W-1:0]   prod [ROWS];

  ////////////////////////////////////////////////////////////
  // Per-row products, shared pixel
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      prod[r] = pixel * $signed(weights[r]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset || mac_clear) begin
      for (int r = 0; r < ROWS; r++) begin
        acc[r] <= '0;
      end
    end else if (mac_en) begin
      for (int r = 0; r < ROWS; r++) begin
        acc[r] <= acc[r] + prod[r];  // Sign extends the product
      end
    end
  end

  // Read port for the drain loop
  assign row_acc = acc[row_idx];

  // Clear only comes after the drain, never mid-tile
  a_en_clear: assert property (@(posedge clk) disable iff (reset)
    !(mac_en && mac_clear));

endmodule

// ==== hw/qcbr_bias_add.sv ====
`timescale 1ns/1ps

module qcbr_bias_add import qcbr_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         bias_en,
  input  logic signed [ACC_W-1:0]      row_acc,
  input  logic [ROW_IDX_W-1:0]         row_idx,
  input  logic [ROWS-1:0][ACC_W-1:0]   biases,
  output logic signed [ACC_W-1:0]      biased
);

  logic signed [ACC_W-1:0] row_bias;

  // Bias of the row being drained
  assign row_bias = $signed(biases[row_idx]);

  always_ff @(posedge clk) begin
    if (reset) begin
      biased <= '0;
    end else if (bias_en) begin
      biased <= row_acc + row_bias;  // Wraps like the accumulator
    end
  end

endmodule

// ==== hw/qcbr_out_fifo.sv ====
`timescale 1ns/1ps

module qcbr_out_fifo import qcbr_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                fifo_wr,
  input  logic [DATA_W-1:0]   wr_data,
  input  logic                out_ack,
  output logic [FIFO_AW:0]    fifo_free,
  output logic                out_req,
  output logic [DATA_W-1:0]   out_data
);

  logic [DATA_W-1:0]   mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]  wr_ptr;
  logic [FIFO_AW-1:0]  rd_ptr;
  logic [FIFO_AW:0]    count;
  logic                wait_low;  // Popped, waiting for ack to drop
  logic                pop;
  logic                full;

  assign full      = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign fifo_free = (FIFO_AW + 1)'(FIFO_DEPTH) - count;
  assign pop       = out_req && out_ack;
  assign out_data  = mem[rd_ptr];  // Held while out_req is up

  always_ff @(posedge clk) begin
    if (fifo_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (fifo_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (FIFO_AW + 1)'(fifo_wr) - (FIFO_AW + 1)'(pop);
    end
  end

  ////////////////////////////////////////////////////////////
  // Four-phase read side: idle, request, wait for ack low
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_req  <= 1'b0;
      wait_low <= 1'b0;
    end else if (out_req) begin
      if (out_ack) begin
        out_req  <= 1'b0;
        wait_low <= 1'b1;
      end
    end else if (wait_low) begin
      if (!out_ack) begin
        wait_low <= 1'b0;
      end
    end else if (count != '0) begin
      out_req <= 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    fifo_wr |-> !full);

  // Offered word stays put until the receiver takes it
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    out_req && !out_ack |=> out_req && $stable(out_data));

endmodule

// ==== hw/qcbr_relu_scale.sv ====
`timescale 1ns/1ps

module qcbr_relu_scale import qcbr_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       act_en,
  input  logic                       relu_mode,
  input  logic signed [ACC_W-1:0]    biased,
  input  logic [SCALE_W-1:0]         scale,
  input  logic [SHIFT_W-1:0]         shift,
  output logic signed [DATA_W-1:0]   result
);

  logic signed [ACC_W-1:0]         clamped;
  logic signed [ACC_W+SCALE_W:0]   prod;     // Scale gets a zero sign bit
  logic signed [ACC_W+SCALE_W:0]   shifted;
  logic signed [DATA_W-1:0]        sat;

  always_comb begin
    // Optional ReLU
    clamped = (relu_mode && biased[ACC_W-1]) ? '0 : biased;
    prod    = clamped * $signed({1'b0, scale});
    shifted = prod >>> shift;

    // Clip to the int8 range
    if (shifted > ((2 ** (DATA_W - 1)) - 1)) begin
      sat = DATA_W'((2 ** (DATA_W - 1)) - 1);
    end else if (shifted < -(2 ** (DATA_W - 1))) begin
      sat = DATA_W'(-(2 ** (DATA_W - 1)));
    end else begin
      sat = shifted[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (act_en) begin
      result <= sat;
    end
  end

endmodule

// ==== hw/qcbr_top.sv ====
`timescale 1ns/1ps

module qcbr_top import qcbr_pkg::*; (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          tile_start,
  input  logic signed [DATA_W-1:0]      pixel,
  input  logic [ROWS-1:0][DATA_W-1:0]   weights,
  input  logic [ROWS-1:0][ACC_W-1:0]    biases,
  input  logic                          relu_init,
  input  logic [CNT_W-1:0]              pixel_count_init,
  input  logic [SCALE_W-1:0]            scale,
  input  logic [SHIFT_W-1:0]            shift,
  input  logic                          out_ack,
  output logic                          tile_busy,
  output logic                          tile_done,
  output logic                          out_req,
  output logic [DATA_W-1:0]             out_data
);

  logic                        relu_mode;
  logic                        mac_en;
  logic                        mac_clear;
  logic [ROW_IDX_W-1:0]        row_idx;
  logic                        bias_en;
  logic                        act_en;
  logic                        fifo_wr;
  logic [FIFO_AW:0]            fifo_free;
  logic signed [ACC_W-1:0]     row_acc;
  logic signed [ACC_W-1:0]     biased;
  logic signed [DATA_W-1:0]    result;

  qcbr_core_ctrl u_ctrl (
    .clk              (clk),
    .reset            (reset),
    .tile_start       (tile_start),
    .relu_init        (relu_init),
    .pixel_count_init (pixel_count_init),
    .fifo_free        (fifo_free),
    .relu_mode        (relu_mode),
    .mac_en           (mac_en),
    .mac_clear        (mac_clear),
    .row_idx          (row_idx),
    .bias_en          (bias_en),
    .act_en           (act_en),
    .fifo_wr          (fifo_wr),
    .tile_busy        (tile_busy),
    .tile_done        (tile_done)
  );

  qcbr_mac_array u_array (
    .clk       (clk),
    .reset     (reset),
    .mac_en    (mac_en),
    .mac_clear (mac_clear),
    .pixel     (pixel),
    .weights   (weights),
    .row_idx   (row_idx),
    .row_acc   (row_acc)
  );

  qcbr_bias_add u_bias (
    .clk     (clk),
    .reset   (reset),
    .bias_en (bias_en),
    .row_acc (row_acc),
    .row_idx (row_idx),
    .biases  (biases),
    .biased  (biased)
  );

  qcbr_relu_scale u_act (
    .clk       (clk),
    .reset     (reset),
    .act_en    (act_en),
    .relu_mode (relu_mode),
    .biased    (biased),
    .scale     (scale),
    .shift     (shift),
    .result    (result)
  );

  qcbr_out_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .fifo_wr   (fifo_wr),
    .wr_data   (result),
    .out_ack   (out_ack),
    .fifo_free (fifo_free),
    .out_req   (out_req),
    .out_data  (out_data)
  );

endmodule

// ==== tests/qcbr_tb.sv ====
`timescale 1ns/1ps

module qcbr_tb import qcbr_pkg::*; ();

  localparam int NUM_TILES       = 8;
  localparam int MAX_PIX         = 16;
  localparam int WATCHDOG_CYCLES = NUM_TILES * (MAX_PIX + ROWS + 3) * 12 + 2000;

  // Tile kinds: small positive, large negative, full range
  localparam int K_SMALL = 0;
  localparam int K_NEG   = 1;
  localparam int K_RAND  = 2;
  localparam int PIX_LO  [3] = '{0, 100, -128};
  localparam int PIX_HI  [3] = '{15, 127, 127};
  localparam int WT_LO   [3] = '{0, -128, -128};
  localparam int WT_HI   [3] = '{7, -100, 127};
  localparam int BIAS_LO [3] = '{0, -1000, -50000};
  localparam int BIAS_HI [3] = '{63, 0, 50000};

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        tile_start;
  logic signed [DATA_W-1:0]    pixel;
  logic [ROWS-1:0][DATA_W-1:0] weights;
  logic [ROWS-1:0][ACC_W-1:0]  biases;
  logic                        relu_init;
  logic [CNT_W-1:0]            pixel_count_init;
  logic [SCALE_W-1:0]          scale;
  logic [SHIFT_W-1:0]          shift;
  logic                        out_ack;
  logic                        tile_busy;
  logic                        tile_done;
  logic                        out_req;
  logic [DATA_W-1:0]           out_data;

  logic [31:0] lfsr = 32'habe7a7e7;
  int          mismatch_errs  = 0;
  int          protocol_errs  = 0;
  int          done_cnt       = 0;
  int          tiles_accepted = 0;
  int          results_seen   = 0;
  bit          slow_ack       = 1'b0;  // Adds 8 cycles to every ack

  // Model of the tile in flight
  int                          pix_q [$];
  logic [ROWS-1:0][DATA_W-1:0] wt_q [$];
  int                          tile_bias [ROWS];
  bit                          cur_relu;
  logic [SCALE_W-1:0]          cur_scale;
  logic [SHIFT_W-1:0]          cur_shift;
  int                          pix_n;      // Last pixel index
  logic signed [DATA_W-1:0]    exp_q [$];  // Expected results in row order

  always #5 clk = ~clk;

  qcbr_top dut (.*);

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int unsigned span;
    span = hi - lo + 1;
    return lo + int'(rand_bits(24) % span);
  endfunction

  function automatic logic signed [DATA_W-1:0] ref_result(input int row);
    int                      sum;
    int                      w;
    logic signed [ACC_W-1:0] acc;
    longint                  v;
    longint                  sc;
    sum = 0;
    for (int k = 0; k < pix_q.size(); k++) begin
      w = $signed(wt_q[k][row]);
      sum += pix_q[k] * w;
    end
    acc = sum + tile_bias[row];  // 32-bit wrap, as the accumulator
    if (cur_relu && acc < 0) begin
      acc = 0;
    end
    sc = cur_scale;
    v  = acc;
    v  = (v * sc) >>> cur_shift;
    if (v > 127) return 8'sd127;
    if (v < -128) return -8'sd128;
    return DATA_W'(v);
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic check_result(input logic signed [DATA_W-1:0] got,
                              input logic signed [DATA_W-1:0] exp, input int idx);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch out_data (result %0d): got 0x%h, expected 0x%h", idx, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input bit ok, input string msg);
    if (!ok) begin
      protocol_errs++;
      $display("%0t: %s", $time, msg);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, all on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic do_reset(input bit relu, input int count);
    reset            = 1'b1;
    relu_init        = relu;
    pixel_count_init = CNT_W'(count);
    repeat (16) @(negedge clk);
    reset    = 1'b0;
    cur_relu = relu;
    pix_n    = count;
    @(negedge clk);
    check_flag(!tile_busy && !tile_done && !out_req, "outputs not idle after reset");
  endtask

  task automatic run_tile(input int kind, input logic [SCALE_W-1:0] sc,
                          input logic [SHIFT_W-1:0] sh, input bit poke);
    int                          v;
    logic [ROWS-1:0][DATA_W-1:0] w;
    // Idle engine with room for a whole tile
    do begin
      @(negedge clk);
    end while (tile_busy || exp_q.size() > FIFO_DEPTH - ROWS);
    pix_q.delete();
    wt_q.delete();
    cur_scale = sc;
    cur_shift = sh;
    scale     = sc;
    shift     = sh;
    for (int r = 0; r < ROWS; r++) begin
      tile_bias[r] = rand_range(BIAS_LO[kind], BIAS_HI[kind]);
      biases[r]    = ACC_W'(tile_bias[r]);
    end
    for (int k = 0; k <= pix_n; k++) begin
      if (k > 0) begin
        @(negedge clk);
      end
      if (k == 1) begin
        check_flag(tile_busy, "tile_busy did not rise after tile_start");
      end
      v = rand_range(PIX_LO[kind], PIX_HI[kind]);
      for (int r = 0; r < ROWS; r++) begin
        w[r] = DATA_W'(rand_range(WT_LO[kind], WT_HI[kind]));
      end
      pixel      = DATA_W'(v);
      weights    = w;
      tile_start = (k == 0);
      pix_q.push_back(v);
      wt_q.push_back(w);
    end
    @(negedge clk);
    tile_start = poke;  // Extra strobe while busy, in drain cycle 0
    pixel      = '0;
    @(negedge clk);
    tile_start = 1'b0;
    tiles_accepted++;
    for (int r = 0; r < ROWS; r++) begin
      exp_q.push_back(ref_result(r));
    end
  endtask

  task automatic drain_all();
    do begin
      @(negedge clk);
    end while (tile_busy || exp_q.size() != 0 || out_ack);
    repeat (4) @(negedge clk);
    check_flag(!out_req, "out_req raised with no result left in the FIFO");
    check_count("tile_done pulses", done_cnt, tiles_accepted);
    check_count("result count", results_seen, tiles_accepted * ROWS);
  endtask

  always @(negedge clk) begin
    if (!reset && tile_done) begin
      done_cnt++;
    end
  end

  // Receiver side of the four-phase handshake, compares each result
  initial begin : receive_compare
    logic signed [DATA_W-1:0] got;
    int                       delay;
    out_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset && out_req) begin
        got   = out_data;
        delay = rand_bits(3) + (slow_ack ? 8 : 0);
        repeat (delay) begin
          @(negedge clk);
          check_flag(out_req && out_data == got, "offered result changed before out_ack");
        end
        out_ack = 1'b1;
        do begin
          @(negedge clk);
        end while (out_req);
        if (exp_q.size() == 0) begin
          check_flag(1'b0, "result arrived with no result expected");
        end else begin
          check_result(got, exp_q.pop_front(), results_seen);
        end
        results_seen++;
        delay = rand_bits(2);
        repeat (delay) begin
          @(negedge clk);
          check_flag(!out_req, "out_req rose again while out_ack was still high");
        end
        out_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    protocol_errs++;
    $display("Timeout after %0d cycles, results still outstanding", WATCHDOG_CYCLES);
    $display("Errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    reset            = 1'b1;
    tile_start       = 1'b0;
    pixel            = '0;
    weights          = '0;
    biases           = '0;
    relu_init        = 1'b0;
    pixel_count_init = '0;
    scale            = '0;
    shift            = '0;

    // ReLU on, 16 pixels per tile
    do_reset(1'b1, 15);
    run_tile(K_SMALL, 16'd1, 5'd4, 1'b0);
    run_tile(K_NEG, 16'd1, 5'd0, 1'b0);      // Every row clamps to zero
    run_tile(K_RAND, 16'hffff, 5'd1, 1'b0);  // Hits the 127 ceiling
    run_tile(K_RAND, 16'd1, 5'd10, 1'b1);
    drain_all();

    // ReLU off, 12 pixels per tile
    do_reset(1'b0, 11);
    run_tile(K_NEG, 16'd1, 5'd4, 1'b0);      // Clips at -128
    run_tile(K_RAND, 16'hffff, 5'd2, 1'b0);
    slow_ack = 1'b1;
    run_tile(K_RAND, 16'd5, 5'd12, 1'b1);
    run_tile(K_SMALL, 16'd3, 5'd5, 1'b1);
    drain_all();

    $display("Errors: %0d mismatch, %0d protocol", mismatch_errs, protocol_errs);
    if (mismatch_errs == 0 && protocol_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
